// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --top-module tb_cpu -f flist.f -o Vtb_cpu
	./obj_dir/Vtb_cpu > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "Simulation failed"; exit 1; fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: cpu.sv
// RV32I pipeline core top level
// Fetch, decode, execute and memory stages around the register file,
// with separate instruction and data buses and stall/flush wiring

`timescale 1ns/1ps
`default_nettype none

module cpu #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000,
	parameter logic [31:0] STACK_POINTER = 32'h1000_0400
)(
	input wire i_clock,
	input wire i_rst_n,

	// Instruction bus
	output logic o_ibus_request,
	input wire i_ibus_ready,
	output logic [31:0] o_ibus_address,
	input wire [31:0] i_ibus_rdata,

	// Data bus
	output logic o_dbus_rw,
	output logic o_dbus_request,
	input wire i_dbus_ready,
	output logic [31:0] o_dbus_address,
	input wire [31:0] i_dbus_rdata,
	output logic [31:0] o_dbus_wdata,

	// Status
	output logic o_execute_busy,
	output logic o_memory_busy,
	output logic o_fault
);
	import cpu_pkg::*;

	fetch_data_t fetch_data;
	decode_data_t decode_data;
	execute_data_t execute_data;
	memory_data_t memory_data;

	logic [4:0] rs1_index, rs2_index;
	logic [31:0] rs1, rs2;
	logic execute_busy, memory_busy, stall;
	logic jump;
	logic [31:0] jump_pc;

	// Either hazard holds the front of the pipe
	assign stall = execute_busy || memory_busy;

	//============================================================
	// Front end

	cpu_fetch #(
		.RESET_VECTOR(RESET_VECTOR)
	) fetch (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_busy(stall),
		.i_jump(jump),
		.i_jump_pc(jump_pc),
		.o_bus_request(o_ibus_request),
		.i_bus_ready(i_ibus_ready),
		.o_bus_address(o_ibus_address),
		.i_bus_rdata(i_ibus_rdata),
		.o_data(fetch_data)
	);

	cpu_decode decode (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_busy(stall),
		.i_flush(jump),
		.i_data(fetch_data),
		.o_rs1_index(rs1_index),
		.o_rs2_index(rs2_index),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_data(decode_data),
		.o_fault(o_fault)
	);

	cpu_registers #(
		.STACK_POINTER(STACK_POINTER)
	) registers (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_rs1_index(rs1_index),
		.i_rs2_index(rs2_index),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.i_wb(memory_data)
	);

	//============================================================
	// Back end

	cpu_execute execute (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_memory_busy(memory_busy),
		.i_data(decode_data),
		.i_wb(memory_data),
		.o_busy(execute_busy),
		.o_jump(jump),
		.o_jump_pc(jump_pc),
		.o_data(execute_data)
	);

	cpu_memory memory (
		.i_clock(i_clock),
		.i_rst_n(i_rst_n),
		.i_data(execute_data),
		.o_bus_rw(o_dbus_rw),
		.o_bus_request(o_dbus_request),
		.i_bus_ready(i_dbus_ready),
		.o_bus_address(o_dbus_address),
		.i_bus_rdata(i_dbus_rdata),
		.o_bus_wdata(o_dbus_wdata),
		.o_busy(memory_busy),
		.o_data(memory_data)
	);

	assign o_execute_busy = execute_busy;
	assign o_memory_busy = memory_busy;

endmodule

`default_nettype wire

// File: cpu_decode.sv
// Decode stage
// Splits the instruction word into a control record, builds the
// immediate, and latches the register values read for it.
// Unknown opcodes raise a sticky fault and become bubbles

`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_busy,
	input wire i_flush,
	input wire cpu_pkg::fetch_data_t i_data,
	output logic [4:0] o_rs1_index,
	output logic [4:0] o_rs2_index,
	input wire [31:0] i_rs1,
	input wire [31:0] i_rs2,
	output cpu_pkg::decode_data_t o_data,
	output logic o_fault
);
	import cpu_pkg::*;

	instr_word_u iw;
	logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	alu_op_e arith_op;
	decode_data_t dec;
	logic illegal;

	assign iw = i_data.instr;

	// Immediates, each from the view that holds its bits
	assign imm_i = {{20{iw.r.funct7[6]}}, iw.r.funct7, iw.r.rs2};
	assign imm_s = {{20{iw.s.imm_hi[6]}}, iw.s.imm_hi, iw.s.imm_lo};
	assign imm_b = {{20{iw.s.imm_hi[6]}}, iw.s.imm_lo[0], iw.s.imm_hi[5:0],
		iw.s.imm_lo[4:1], 1'b0};
	assign imm_u = {iw.r.funct7, iw.r.rs2, iw.r.rs1, iw.r.funct3, 12'd0};
	assign imm_j = {{12{iw.r.funct7[6]}}, iw.r.rs1, iw.r.funct3, iw.r.rs2[0],
		iw.r.funct7[5:0], iw.r.rs2[4:1], 1'b0};

	// Shared by register and immediate forms
	always_comb begin
		case (iw.r.funct3)
			3'd0: arith_op = (iw.r.opcode == OP_REG && iw.r.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'd1: arith_op = ALU_SLL;
			3'd2: arith_op = ALU_SLT;
			3'd3: arith_op = ALU_SLTU;
			3'd4: arith_op = ALU_XOR;
			3'd5: arith_op = iw.r.funct7[5] ? ALU_SRA : ALU_SRL;
			3'd6: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	// Unused source fields stay at x0 so they never forward or interlock
	always_comb begin
		dec = '0;
		illegal = 1'b0;
		dec.valid = i_data.valid;
		dec.pc = i_data.pc;
		dec.rd = iw.r.rd;
		dec.funct3 = iw.r.funct3;
		case (opcode_e'(iw.r.opcode))
			OP_LUI, OP_AUIPC: begin
				dec.imm = imm_u;
				dec.use_imm = 1'b1;
				dec.use_pc = iw.r.opcode == OP_AUIPC;
				dec.writes_rd = 1'b1;
			end
			OP_JAL: begin
				dec.imm = imm_j;
				dec.is_jal = 1'b1;
				dec.writes_rd = 1'b1;
			end
			OP_JALR: begin
				dec.rs1 = iw.r.rs1;
				dec.imm = imm_i;
				dec.is_jalr = 1'b1;
				dec.writes_rd = 1'b1;
			end
			OP_BRANCH: begin
				dec.rs1 = iw.r.rs1;
				dec.rs2 = iw.r.rs2;
				dec.imm = imm_b;
				dec.is_branch = 1'b1;
			end
			OP_LOAD: begin
				dec.rs1 = iw.r.rs1;
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.is_load = 1'b1;
				dec.writes_rd = 1'b1;
				illegal = iw.r.funct3 != 3'b010;
			end
			OP_STORE: begin
				dec.rs1 = iw.s.rs1;
				dec.rs2 = iw.s.rs2;
				dec.imm = imm_s;
				dec.use_imm = 1'b1;
				dec.is_store = 1'b1;
				illegal = iw.s.funct3 != 3'b010;
			end
			OP_IMM: begin
				dec.rs1 = iw.r.rs1;
				dec.imm = imm_i;
				dec.use_imm = 1'b1;
				dec.alu_op = arith_op;
				dec.writes_rd = 1'b1;
			end
			OP_REG: begin
				dec.rs1 = iw.r.rs1;
				dec.rs2 = iw.r.rs2;
				dec.alu_op = arith_op;
				dec.writes_rd = 1'b1;
			end
			default: illegal = 1'b1;
		endcase
	end

	// A held record keeps reading its own sources
	assign o_rs1_index = i_busy ? o_data.rs1 : dec.rs1;
	assign o_rs2_index = i_busy ? o_data.rs2 : dec.rs2;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data.valid <= 1'b0;
			o_fault <= 1'b0;
		end else if (i_flush) begin
			o_data.valid <= 1'b0;
		end else if (i_busy) begin
			// Pick up register writes that land during the stall
			o_data.rs1_value <= i_rs1;
			o_data.rs2_value <= i_rs2;
		end else begin
			o_data <= dec;
			o_data.valid <= i_data.valid && !illegal;
			o_data.rs1_value <= i_rs1;
			o_data.rs2_value <= i_rs2;
			if (i_data.valid && illegal)
				o_fault <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: cpu_execute.sv
// Execute stage
// Operand forwarding, load-use interlock, ALU, branch compare and
// jump target; taken branches and jumps redirect fetch

`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_memory_busy,
	input wire cpu_pkg::decode_data_t i_data,
	input wire cpu_pkg::memory_data_t i_wb,
	output logic o_busy,
	output logic o_jump,
	output logic [31:0] o_jump_pc,
	output cpu_pkg::execute_data_t o_data
);
	import cpu_pkg::*;

	logic [31:0] rs1_value, rs2_value;
	logic [31:0] op_a, op_b;
	logic [31:0] alu_result;
	logic branch_cond, taken;

	// Youngest producer wins, x0 is never forwarded
	function automatic logic [31:0] forward_operand(input logic [4:0] index,
		input logic [31:0] value);
		if (index == 5'd0)
			return value;
		if (o_data.valid && o_data.writes_rd && o_data.rd == index)
			return o_data.result;
		if (i_wb.valid && i_wb.writes_rd && i_wb.rd == index)
			return i_wb.value;
		return value;
	endfunction

	always_comb begin
		rs1_value = forward_operand(i_data.rs1, i_data.rs1_value);
		rs2_value = forward_operand(i_data.rs2, i_data.rs2_value);
		op_a = i_data.use_pc ? i_data.pc : rs1_value;
		op_b = i_data.use_imm ? i_data.imm : rs2_value;
	end

	always_comb begin
		case (i_data.alu_op)
			ALU_SUB: alu_result = op_a - op_b;
			ALU_SLL: alu_result = op_a << op_b[4:0];
			ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_result = {31'd0, op_a < op_b};
			ALU_XOR: alu_result = op_a ^ op_b;
			ALU_SRL: alu_result = op_a >> op_b[4:0];
			ALU_SRA: alu_result = $signed(op_a) >>> op_b[4:0];
			ALU_OR: alu_result = op_a | op_b;
			ALU_AND: alu_result = op_a & op_b;
			default: alu_result = op_a + op_b;
		endcase
	end

	always_comb begin
		case (i_data.funct3)
			3'b000: branch_cond = rs1_value == rs2_value;
			3'b001: branch_cond = rs1_value != rs2_value;
			3'b100: branch_cond = $signed(rs1_value) < $signed(rs2_value);
			3'b101: branch_cond = $signed(rs1_value) >= $signed(rs2_value);
			3'b110: branch_cond = rs1_value < rs2_value;
			3'b111: branch_cond = rs1_value >= rs2_value;
			default: branch_cond = 1'b0;
		endcase
	end

	// Load in the next stage still holds an address, not its data
	assign o_busy = i_data.valid && o_data.valid && o_data.is_load && o_data.rd != 5'd0 &&
		(o_data.rd == i_data.rs1 || o_data.rd == i_data.rs2);

	assign taken = i_data.is_jal || i_data.is_jalr || (i_data.is_branch && branch_cond);
	assign o_jump = i_data.valid && taken && !o_busy && !i_memory_busy;
	assign o_jump_pc = i_data.is_jalr ? ((rs1_value + i_data.imm) & ~32'd1) :
		i_data.pc + i_data.imm;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data.valid <= 1'b0;
		end else if (!i_memory_busy) begin
			o_data.valid <= i_data.valid && !o_busy;
			o_data.rd <= i_data.rd;
			o_data.writes_rd <= i_data.writes_rd;
			o_data.is_load <= i_data.is_load;
			o_data.is_store <= i_data.is_store;
			// Link value for jumps
			o_data.result <= (i_data.is_jal || i_data.is_jalr) ? i_data.pc + 32'd4 : alu_result;
			o_data.store_data <= rs2_value;
		end
	end

endmodule

`default_nettype wire

// File: cpu_fetch.sv
// Fetch stage
// Keeps the pc, requests instructions over the instruction bus and
// hands them to decode, with a one-entry holding slot for stalls

`timescale 1ns/1ps
`default_nettype none

module cpu_fetch #(
	parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire i_busy,
	input wire i_jump,
	input wire [31:0] i_jump_pc,
	output logic o_bus_request,
	input wire i_bus_ready,
	output logic [31:0] o_bus_address,
	input wire [31:0] i_bus_rdata,
	output cpu_pkg::fetch_data_t o_data
);
	import cpu_pkg::*;

	logic [31:0] pc, redirect_pc;
	logic running, discard, done, slot_free;
	fetch_data_t held, fetched;

	// No new request while an instruction waits in the holding slot
	assign o_bus_request = running && !held.valid;
	assign o_bus_address = pc;
	assign done = o_bus_request && i_bus_ready;

	// Output slot can take a record when empty or consumed by decode
	assign slot_free = !o_data.valid || !i_busy;

	always_comb begin
		fetched.valid = done && !discard;
		fetched.pc = pc;
		fetched.instr = i_bus_rdata;
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			running <= 1'b0;
			discard <= 1'b0;
			pc <= RESET_VECTOR;
			redirect_pc <= '0;
			held.valid <= 1'b0;
			o_data.valid <= 1'b0;
		end else begin
			running <= 1'b1;
			if (i_jump) begin
				o_data.valid <= 1'b0;
				held.valid <= 1'b0;
				// Address must stay put until the open request ends
				if (o_bus_request && !i_bus_ready) begin
					discard <= 1'b1;
					redirect_pc <= i_jump_pc;
				end else begin
					pc <= i_jump_pc;
				end
			end else begin
				if (done) begin
					pc <= discard ? redirect_pc : pc + 32'd4;
					discard <= 1'b0;
				end
				if (slot_free) begin
					o_data <= held.valid ? held : fetched;
					held.valid <= 1'b0;
				end else if (fetched.valid) begin
					held <= fetched;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: cpu_memory.sv
// Memory and writeback stage
// Runs data-bus transactions for word loads and stores and registers
// the writeback record, which also drives the register write port

`timescale 1ns/1ps
`default_nettype none

module cpu_memory (
	input wire i_clock,
	input wire i_rst_n,
	input wire cpu_pkg::execute_data_t i_data,
	output logic o_bus_rw,
	output logic o_bus_request,
	input wire i_bus_ready,
	output logic [31:0] o_bus_address,
	input wire [31:0] i_bus_rdata,
	output logic [31:0] o_bus_wdata,
	output logic o_busy,
	output cpu_pkg::memory_data_t o_data
);
	logic access;

	// Execute holds its record while busy, so the bus fields stay steady
	assign access = i_data.valid && (i_data.is_load || i_data.is_store);
	assign o_bus_request = access;
	assign o_bus_rw = i_data.is_store;
	assign o_bus_address = i_data.result;
	assign o_bus_wdata = i_data.store_data;
	assign o_busy = access && !i_bus_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data.valid <= 1'b0;
		end else begin
			// One writeback record per instruction
			o_data.valid <= i_data.valid && !o_busy;
			o_data.rd <= i_data.rd;
			o_data.writes_rd <= i_data.writes_rd;
			o_data.value <= i_data.is_load ? i_bus_rdata : i_data.result;
		end
	end

endmodule

`default_nettype wire

// File: cpu_pkg.sv
// RV32I pipeline core shared types
// Stage records, the instruction word in its two views, and the
// opcode and ALU operation encodings used across the pipeline

`default_nettype none

package cpu_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	//============================================================
	// Instruction word

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_reg_t;

	// Store format, immediate split around the register fields
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} instr_store_t;

	typedef union packed {
		instr_reg_t   r;
		instr_store_t s;
	} instr_word_u;

	//============================================================
	// Stage records

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		instr_word_u instr;
	} fetch_data_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] rs1_value;
		logic [31:0] rs2_value;
		logic [31:0] imm;
		alu_op_e     alu_op;
		logic        use_imm;
		logic        use_pc;
		logic        is_load;
		logic        is_store;
		logic        is_branch;
		logic        is_jal;
		logic        is_jalr;
		logic        writes_rd;
		logic [2:0]  funct3;
	} decode_data_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic        writes_rd;
		logic        is_load;
		logic        is_store;
		logic [31:0] result;
		logic [31:0] store_data;
	} execute_data_t;

	// Writeback record
	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic        writes_rd;
		logic [31:0] value;
	} memory_data_t;

endpackage

`default_nettype wire

// File: cpu_registers.sv
// Integer register file
// x1..x31 with two combinational read ports and one write port
// fed by the writeback record; x2 starts at the stack pointer

`timescale 1ns/1ps
`default_nettype none

module cpu_registers #(
	parameter logic [31:0] STACK_POINTER = 32'h1000_0400
)(
	input wire i_clock,
	input wire i_rst_n,
	input wire [4:0] i_rs1_index,
	input wire [4:0] i_rs2_index,
	output logic [31:0] o_rs1,
	output logic [31:0] o_rs2,
	input wire cpu_pkg::memory_data_t i_wb
);
	logic [31:0] regs [1:31];
	logic wr_en;

	assign wr_en = i_wb.valid && i_wb.writes_rd && i_wb.rd != 5'd0;

	// Write in flight is visible to readers in the same cycle
	function automatic logic [31:0] read_port(input logic [4:0] index);
		if (index == 5'd0)
			return '0;
		if (wr_en && index == i_wb.rd)
			return i_wb.value;
		return regs[index];
	endfunction

	always_comb begin
		o_rs1 = read_port(i_rs1_index);
		o_rs2 = read_port(i_rs2_index);
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= (i == 2) ? STACK_POINTER : '0;
		end else if (wr_en) begin
			regs[i_wb.rd] <= i_wb.value;
		end
	end

endmodule

`default_nettype wire

// File: cpu_tests.hex
// Header: program length in words, expected store count
// Then program words from the reset vector, then expected stores as address data pairs
00000026 00000009
// ALU, immediates, LUI, AUIPC and forwarding
10000513 123450B7 67808093 00152023
FFB00193 40308233 4011D293 00524333
00652223 0011A3B3 00001417 007404B3
00952423
// Load followed at once by its use
00052583 00158613 00C52623
// Six branches, each taken one skips a bad store
00738463 04052023 00739463 00752823
0071C463 04052023 0071D463 00352A23
0071E463 00452C23 0071F463 04052023
// JAL, JALR, illegal opcode, then the self loop
0080076F 04052023 00E52E23 08C00793
00078867 04052023 04052023 03052023
FFFFFFFF 0000006F
// Expected stores
00000100 12345678
00000104 EDCBA980
00000108 00001029
0000010C 12345679
00000110 00000001
00000114 FFFFFFFB
00000118 1234567D
0000011C 00000074
00000120 00000084

// File: flist.f
cpu_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_registers.sv
cpu_execute.sv
cpu_memory.sv
cpu.sv
tb_cpu_asserts.sv
tb_cpu.sv

// File: tb_cpu.sv
// Testbench for the RV32I pipeline core
// Instruction and data memory models with random ready stalls,
// in-order store checking against the test file, fault and stall
// flag checks, watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	localparam int TESTS_MAX = 128;
	localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;
	localparam logic [31:0] STACK_POINTER = 32'h1000_0400;

	logic clock, rst_n;
	logic ibus_request, ibus_ready;
	logic [31:0] ibus_address, ibus_rdata, ibus_word;
	logic dbus_rw, dbus_request, dbus_ready;
	logic [31:0] dbus_address, dbus_rdata, dbus_wdata;
	logic [7:0] dbus_index;
	logic execute_busy, memory_busy, fault;

	logic [31:0] tests [0:TESTS_MAX-1];
	logic [31:0] dmem [0:255];
	logic written [0:255];
	int program_length, store_count, store_index;
	logic [15:0] lfsr;
	logic fault_seen;
	logic interlock_prev;

	cpu #(
		.RESET_VECTOR(RESET_VECTOR),
		.STACK_POINTER(STACK_POINTER)
	) uut (
		.i_clock(clock),
		.i_rst_n(rst_n),
		.o_ibus_request(ibus_request),
		.i_ibus_ready(ibus_ready),
		.o_ibus_address(ibus_address),
		.i_ibus_rdata(ibus_rdata),
		.o_dbus_rw(dbus_rw),
		.o_dbus_request(dbus_request),
		.i_dbus_ready(dbus_ready),
		.o_dbus_address(dbus_address),
		.i_dbus_rdata(dbus_rdata),
		.o_dbus_wdata(dbus_wdata),
		.o_execute_busy(execute_busy),
		.o_memory_busy(memory_busy),
		.o_fault(fault)
	);

	always #4 clock = ~clock;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
	endfunction

	task automatic random_bit(output logic value);
		lfsr = lfsr_step(lfsr);
		value = lfsr[0];
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_store(input logic [31:0] address, input logic [31:0] data);
		logic [31:0] exp_address;
		logic [31:0] exp_data;
		exp_address = tests[2 + program_length + 2 * store_index];
		exp_data = tests[3 + program_length + 2 * store_index];
		if (address !== exp_address)
			fail_run($sformatf("FAILED store %0d address: expected %h, actual %h",
				store_index, exp_address, address));
		else if (data !== exp_data)
			fail_run($sformatf("FAILED store %0d data: expected %h, actual %h",
				store_index, exp_data, data));
	endtask

	task automatic check_fault(input logic expected);
		if (fault !== expected)
			fail_run($sformatf("FAILED fault flag: expected %b, actual %b", expected, fault));
	endtask

	task automatic check_busy(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			fail_run($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
	endtask

	//============================================================
	// Memory models

	// Words past the program read as NOP
	always_comb begin
		ibus_word = (ibus_address - RESET_VECTOR) >> 2;
		if (ibus_word < program_length)
			ibus_rdata = tests[2 + int'(ibus_word)];
		else
			ibus_rdata = 32'h0000_0013;
	end

	// Unwritten words read back a pattern of their address
	assign dbus_index = dbus_address[9:2];
	always_comb begin
		if (dbus_address[31:10] == '0 && written[dbus_index])
			dbus_rdata = dmem[dbus_index];
		else
			dbus_rdata = dbus_address ^ 32'hC0DE_5A5A;
	end

	always @(posedge clock) begin : drive_ready
		logic value;
		#1;
		random_bit(value);
		ibus_ready = value;
		random_bit(value);
		dbus_ready = value;
	end

	// A request with ready at this point completes on the next rising edge
	always @(negedge clock) begin
		if (rst_n && dbus_request && dbus_ready && dbus_rw) begin
			if (store_index >= store_count) begin
				fail_run("a store happened after the last expected store");
			end else begin
				if (store_index < store_count - 1)
					check_fault(1'b0);
				check_store(dbus_address, dbus_wdata);
				dmem[dbus_index] = dbus_wdata;
				written[dbus_index] = 1'b1;
				store_index = store_index + 1;
			end
		end
		if (fault_seen && !fault)
			fail_run("fault flag dropped after it was raised");
		if (fault)
			fault_seen = 1'b1;
	end

	// Stall flags against the data bus state
	always @(negedge clock) begin
		if (rst_n) begin
			check_busy("memory busy", dbus_request && !dbus_ready, memory_busy);
			// Interlock only while a load waits on the data bus
			if (execute_busy && !(dbus_request && !dbus_rw))
				fail_run("execute busy raised with no load on the data bus");
			if (execute_busy && interlock_prev)
				fail_run("execute busy lasted past the cycle its load completed");
			interlock_prev = execute_busy && !memory_busy;
		end
	end

	//============================================================
	// Main sequence

	initial begin
		clock = 1'b0;
		rst_n = 1'b0;
		ibus_ready = 1'b0;
		dbus_ready = 1'b0;
		lfsr = 16'd2;
		store_index = 0;
		fault_seen = 1'b0;
		interlock_prev = 1'b0;
		for (int i = 0; i < 256; i++)
			written[i] = 1'b0;
		$readmemh("cpu_tests.hex", tests);
		program_length = int'(tests[0]);
		store_count = int'(tests[1]);
		repeat (8) @(posedge clock);
		#1;
		rst_n = 1'b1;
		while (store_index < store_count)
			@(posedge clock);
		repeat (20) @(posedge clock);
		if (!fault_seen) begin
			fail_run("illegal opcode did not raise the fault flag");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

	// 64 cycles per program word and four times that for stalls
	initial begin
		#1;
		repeat (program_length * 64 * 4 + 32) @(posedge clock);
		fail_run("watchdog expired before all stores were seen");
	end

endmodule

`default_nettype wire

// File: tb_cpu_asserts.sv
// Bus checks for the pipeline core
// Request fields hold steady until ready, and both buses are idle in reset

`timescale 1ns/1ps
`default_nettype none

module tb_cpu_asserts (
	input wire i_clock,
	input wire i_rst_n,
	input wire i_ibus_request,
	input wire i_ibus_ready,
	input wire [31:0] i_ibus_address,
	input wire i_dbus_request,
	input wire i_dbus_ready,
	input wire i_dbus_rw,
	input wire [31:0] i_dbus_address,
	input wire [31:0] i_dbus_wdata
);

	ibus_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_ibus_request && !i_ibus_ready) |=> (i_ibus_request && $stable(i_ibus_address)))
		else $error("instruction bus request changed before ready");

	dbus_hold: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_dbus_request && !i_dbus_ready) |=> (i_dbus_request && $stable(i_dbus_address)
		&& $stable(i_dbus_rw) && $stable(i_dbus_wdata)))
		else $error("data bus request changed before ready");

	// Both buses idle while reset is held
	reset_idle: assert property (@(posedge i_clock)
		!i_rst_n |-> (!i_ibus_request && !i_dbus_request))
		else $error("bus request raised during reset");

endmodule

bind cpu tb_cpu_asserts asserts (
	.i_clock(i_clock),
	.i_rst_n(i_rst_n),
	.i_ibus_request(o_ibus_request),
	.i_ibus_ready(i_ibus_ready),
	.i_ibus_address(o_ibus_address),
	.i_dbus_request(o_dbus_request),
	.i_dbus_ready(i_dbus_ready),
	.i_dbus_rw(o_dbus_rw),
	.i_dbus_address(o_dbus_address),
	.i_dbus_wdata(o_dbus_wdata)
);

`default_nettype wire
